//--- include/ps2_display_defines.svh
`ifndef PS2_DISPLAY_DEFINES_SVH
`define PS2_DISPLAY_DEFINES_SVH

// receive FIFO holds 2**PS2_FIFO_AW bytes
`define PS2_FIFO_AW 3

// prefix sent by the keyboard before the code of a released key
`define PS2_BREAK_CODE 8'hF0

// flops on ps2_clk and ps2_dat before any logic looks at them
`define PS2_SYNC_STAGES 2

`endif

//--- verilog/ps2_display_pkg.sv
`default_nettype none

package ps2_display_pkg;

    // one byte as it comes off the PS/2 line
    typedef logic [7:0] scan_code_t;

    // bits 0..6 are segments a..g and bit 7 is the dot, all active low
    typedef logic [7:0] seg_pattern_t;

    typedef enum logic [2:0] {
        IDLE,       // nothing to do until the FIFO has a byte
        TAKE,       // byte at the FIFO head, look at it
        POP_MAKE,   // remove a make code
        POP_BREAK,  // remove the 0xF0 prefix
        WAIT_CODE,  // the released key's code has not arrived yet
        POP_CODE    // remove the released key's code
    } tracker_state_e;

endpackage

`default_nettype wire

//--- verilog/ps2_receiver.sv
`default_nettype none

`include "ps2_display_defines.svh"

module ps2_receiver
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ps2_clk,
    input  logic                        ps2_dat,
    input  logic                        nextdata_n,
    output ps2_display_pkg::scan_code_t data,
    output logic                        ready,
    output logic                        overflow
);

    localparam int FIFO_DEPTH = 1 << `PS2_FIFO_AW;

    logic [`PS2_SYNC_STAGES-1:0]  clk_sync;
    logic [`PS2_SYNC_STAGES-1:0]  dat_sync;
    logic                         clk_prev;
    logic                         clk_fall;
    logic                         dat_bit;
    logic [9:0]                   frame;
    logic [3:0]                   bit_cnt;
    logic                         frame_ok;
    ps2_display_pkg::scan_code_t  fifo_mem [FIFO_DEPTH];
    logic [`PS2_FIFO_AW:0]        wr_ptr;
    logic [`PS2_FIFO_AW:0]        rd_ptr;
    logic                         fifo_full;

    // both lines idle high, so the synchronizer comes out of reset at ones
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= '1;
            dat_sync <= '1;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[`PS2_SYNC_STAGES-2:0], ps2_clk};
            dat_sync <= {dat_sync[`PS2_SYNC_STAGES-2:0], ps2_dat};
            clk_prev <= clk_sync[`PS2_SYNC_STAGES-1];
        end
    end

    assign clk_fall = clk_prev && !clk_sync[`PS2_SYNC_STAGES-1];
    assign dat_bit  = dat_sync[`PS2_SYNC_STAGES-1];

    // after ten shifts frame[0] is the start bit, frame[8:1] the byte, frame[9] parity
    always_ff @(posedge clk)
    begin
        if (clk_fall && bit_cnt != 4'd10)
            frame <= {dat_bit, frame[9:1]};
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt  <= 4'd0;
            frame_ok <= 1'b0;
        end
        else
        begin
            frame_ok <= 1'b0;
            if (clk_fall)
            begin
                if (bit_cnt == 4'd10)
                begin
                    bit_cnt  <= 4'd0;
                    frame_ok <= !frame[0] && dat_bit && ^frame[9:1]; // stop bit is on the line now
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // one extra bit on the pointers tells full from empty
    assign fifo_full = (wr_ptr[`PS2_FIFO_AW] != rd_ptr[`PS2_FIFO_AW]) &&
                       (wr_ptr[`PS2_FIFO_AW-1:0] == rd_ptr[`PS2_FIFO_AW-1:0]);
    assign ready     = (wr_ptr != rd_ptr);
    assign data      = fifo_mem[rd_ptr[`PS2_FIFO_AW-1:0]];

    always_ff @(posedge clk)
    begin
        if (frame_ok && !fifo_full)
            fifo_mem[wr_ptr[`PS2_FIFO_AW-1:0]] <= frame[8:1];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr   <= '0;
            overflow <= 1'b0;
        end
        else if (frame_ok)
        begin
            if (fifo_full)
                overflow <= 1'b1; // byte is lost, flag sticks until reset
            else
                wr_ptr <= wr_ptr + 1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            rd_ptr <= '0;
        else if (!nextdata_n && ready)
            rd_ptr <= rd_ptr + 1;
    end

endmodule

`default_nettype wire

//--- verilog/key_tracker.sv
`default_nettype none

`include "ps2_display_defines.svh"

module key_tracker
(
    input  logic                        clk,
    input  logic                        rst,
    input  ps2_display_pkg::scan_code_t data,
    input  logic                        ready,
    input  logic                        overflow,
    output logic                        nextdata_n,
    output ps2_display_pkg::scan_code_t key_code,
    output logic                        blank
);

    ps2_display_pkg::tracker_state_e state;
    ps2_display_pkg::tracker_state_e state_nxt;
    logic                            pop_state;
    logic                            is_break;

    assign is_break  = (data == `PS2_BREAK_CODE);
    assign pop_state = (state == ps2_display_pkg::POP_MAKE)  ||
                       (state == ps2_display_pkg::POP_BREAK) ||
                       (state == ps2_display_pkg::POP_CODE);

    // a POP state is left only once the registered pop strobe has gone out
    always_comb
    begin
        state_nxt = state;
        case (state)
            ps2_display_pkg::IDLE:
                if (ready && !overflow)
                    state_nxt = ps2_display_pkg::TAKE;
            ps2_display_pkg::TAKE:
                if (is_break)
                    state_nxt = ps2_display_pkg::POP_BREAK;
                else
                    state_nxt = ps2_display_pkg::POP_MAKE;
            ps2_display_pkg::POP_MAKE:
                if (!nextdata_n)
                    state_nxt = ps2_display_pkg::IDLE;
            ps2_display_pkg::POP_BREAK:
                if (!nextdata_n)
                    state_nxt = ps2_display_pkg::WAIT_CODE;
            ps2_display_pkg::WAIT_CODE:
                if (ready && !overflow)
                    state_nxt = ps2_display_pkg::POP_CODE;
            ps2_display_pkg::POP_CODE:
                if (!nextdata_n)
                    state_nxt = ps2_display_pkg::IDLE;
            default:
                state_nxt = ps2_display_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            state <= ps2_display_pkg::IDLE;
        else
            state <= state_nxt;
    end

    // low for a single clock per POP state
    always_ff @(posedge clk)
    begin
        if (!rst)
            nextdata_n <= 1'b1;
        else
            nextdata_n <= !(pop_state && nextdata_n);
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            key_code <= '0;
            blank    <= 1'b0;
        end
        else if (state == ps2_display_pkg::TAKE && !is_break)
        begin
            key_code <= data;
            blank    <= 1'b0;
        end
        else if (state == ps2_display_pkg::POP_CODE)
        begin
            blank <= 1'b1; // released key's code only blanks, the shown code stays
        end
    end

endmodule

`default_nettype wire

//--- verilog/seg7_decoder.sv
`default_nettype none

module seg7_decoder
(
    input  logic [3:0]                    nibble,
    input  logic                          blank,
    output ps2_display_pkg::seg_pattern_t seg
);

    // patterns are active low with the dot kept dark
    always_comb
    begin
        if (blank)
            seg = 8'hFF;
        else
        begin
            case (nibble)
                4'h0:    seg = 8'hC0;
                4'h1:    seg = 8'hF9;
                4'h2:    seg = 8'hA4;
                4'h3:    seg = 8'hB0;
                4'h4:    seg = 8'h99;
                4'h5:    seg = 8'h92;
                4'h6:    seg = 8'h82;
                4'h7:    seg = 8'hF8;
                4'h8:    seg = 8'h80;
                4'h9:    seg = 8'h90;
                4'hA:    seg = 8'h88;
                4'hB:    seg = 8'h83; // lower case b
                4'hC:    seg = 8'hC6;
                4'hD:    seg = 8'hA1; // lower case d
                4'hE:    seg = 8'h86;
                default: seg = 8'h8E;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/ps2_display.sv
`default_nettype none

module ps2_display
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          ps2_clk,
    input  logic                          ps2_dat,
    output ps2_display_pkg::seg_pattern_t seg_lo,
    output ps2_display_pkg::seg_pattern_t seg_hi
);

    ps2_display_pkg::scan_code_t rx_data;
    logic                        rx_ready;
    logic                        rx_overflow;
    logic                        nextdata_n;
    ps2_display_pkg::scan_code_t key_code;
    logic                        blank;

    ps2_receiver i_receiver
    (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .nextdata_n (nextdata_n),
        .data       (rx_data),
        .ready      (rx_ready),
        .overflow   (rx_overflow)
    );

    key_tracker i_tracker
    (
        .clk        (clk),
        .rst        (rst),
        .data       (rx_data),
        .ready      (rx_ready),
        .overflow   (rx_overflow),
        .nextdata_n (nextdata_n),
        .key_code   (key_code),
        .blank      (blank)
    );

    seg7_decoder i_seg_lo
    (
        .nibble (key_code[3:0]),
        .blank  (blank),
        .seg    (seg_lo)
    );

    seg7_decoder i_seg_hi
    (
        .nibble (key_code[7:4]),
        .blank  (blank),
        .seg    (seg_hi)
    );

endmodule

`default_nettype wire

//--- test/ps2_display_sva.sv
`default_nettype none

module ps2_display_sva
(
    input logic                            clk,
    input logic                            rst,
    input ps2_display_pkg::tracker_state_e state,
    input logic                            nextdata_n,
    input logic                            blank,
    input logic                            overflow
);

    logic in_pop;

    assign in_pop = (state == ps2_display_pkg::POP_MAKE)  ||
                    (state == ps2_display_pkg::POP_BREAK) ||
                    (state == ps2_display_pkg::POP_CODE);

    pop_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        !nextdata_n |=> nextdata_n)
        else $error("nextdata_n stayed low for two cycles");

    pop_in_pop_state: assert property (@(posedge clk) disable iff (!rst)
        !nextdata_n |-> in_pop)
        else $error("nextdata_n low outside a POP state");

    // the released key's code is the only thing that blanks the display
    blank_after_code: assert property (@(posedge clk) disable iff (!rst)
        $rose(blank) |-> $past(state) == ps2_display_pkg::POP_CODE)
        else $error("blank rose without a POP_CODE cycle before it");

    idle_on_overflow: assert property (@(posedge clk) disable iff (!rst)
        (state == ps2_display_pkg::IDLE && overflow) |=> state == ps2_display_pkg::IDLE)
        else $error("tracker left IDLE while overflow was set");

endmodule

bind key_tracker ps2_display_sva i_sva
(
    .clk        (clk),
    .rst        (rst),
    .state      (state),
    .nextdata_n (nextdata_n),
    .blank      (blank),
    .overflow   (overflow)
);

`default_nettype wire

//--- test/ps2_display_tb.sv
`default_nettype none

`include "ps2_display_defines.svh"

module ps2_display_tb;

    localparam int ROWS        = 14;
    localparam int HALF_BIT    = 4;  // clk cycles per ps2_clk phase
    localparam int SETTLE_CLKS = 20;
    localparam int WATCHDOG_TIME = (ROWS * (11 * 2 * HALF_BIT + 30) + 50) * 100;

    // standard hex digits, active low with the dot dark
    localparam ps2_display_pkg::seg_pattern_t GLYPH [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
    };

    logic                          clk;
    logic                          rst;
    logic                          ps2_clk;
    logic                          ps2_dat;
    ps2_display_pkg::seg_pattern_t seg_lo;
    ps2_display_pkg::seg_pattern_t seg_hi;

    // one row per frame: byte, corrupt parity, expected seg_hi, expected seg_lo
    ps2_display_pkg::scan_code_t   row_code [ROWS];
    logic                          row_bad  [ROWS];
    ps2_display_pkg::seg_pattern_t row_hi   [ROWS];
    ps2_display_pkg::seg_pattern_t row_lo   [ROWS];
    int                            n_rows;
    int                            i;

    ps2_display i_dut
    (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg_lo  (seg_lo),
        .seg_hi  (seg_hi)
    );

    initial clk = 1'b0;

    always #50 clk = ~clk;

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    // shown is the code the display should hold, blanked turns both digits off
    task automatic add_row(input ps2_display_pkg::scan_code_t code, input logic bad,
                           input ps2_display_pkg::scan_code_t shown, input logic blanked);
        row_code[n_rows] = code;
        row_bad[n_rows]  = bad;
        row_hi[n_rows]   = blanked ? 8'hFF : GLYPH[shown[7:4]];
        row_lo[n_rows]   = blanked ? 8'hFF : GLYPH[shown[3:0]];
        n_rows = n_rows + 1;
    endtask

    task automatic send_frame(input ps2_display_pkg::scan_code_t code, input logic bad_parity);
        logic [10:0] bits;
        int          b;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0}; // start bit goes out first
        for (b = 0; b < 11; b++)
        begin
            ps2_dat = bits[b];
            wait_cycles(HALF_BIT);
            ps2_clk = 1'b0;
            wait_cycles(HALF_BIT);
            ps2_clk = 1'b1;
        end
    endtask

    task automatic check_display(input string what,
                                 input ps2_display_pkg::seg_pattern_t exp_hi,
                                 input ps2_display_pkg::seg_pattern_t exp_lo);
        assert (seg_hi == exp_hi)
        else
        begin
            $display("error: seg_hi is 0x%02h, expected 0x%02h (%s)", seg_hi, exp_hi, what);
            $display("Test failures found");
            $fatal(1);
        end
        assert (seg_lo == exp_lo)
        else
        begin
            $display("error: seg_lo is 0x%02h, expected 0x%02h (%s)", seg_lo, exp_lo, what);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    initial
    begin
        #(WATCHDOG_TIME);
        $display("timeout: the frame sequence did not complete in the expected time");
        $display("Test failures found");
        $fatal(1);
    end

    initial
    begin
        rst     = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        n_rows  = 0;

        add_row(8'h1C,           1'b0, 8'h1C, 1'b0);
        add_row(`PS2_BREAK_CODE, 1'b0, 8'h1C, 1'b0); // prefix alone changes nothing
        add_row(8'h1C,           1'b0, 8'h1C, 1'b1);
        add_row(8'h23,           1'b0, 8'h23, 1'b0);
        add_row(8'h45,           1'b0, 8'h45, 1'b0);
        add_row(8'h67,           1'b0, 8'h67, 1'b0);
        add_row(8'h89,           1'b0, 8'h89, 1'b0);
        add_row(8'hAB,           1'b0, 8'hAB, 1'b0);
        add_row(8'hCD,           1'b0, 8'hCD, 1'b0);
        add_row(8'hEF,           1'b0, 8'hEF, 1'b0);
        add_row(8'h5A,           1'b1, 8'hEF, 1'b0); // bad parity is dropped
        add_row(`PS2_BREAK_CODE, 1'b0, 8'hEF, 1'b0);
        add_row(8'h33,           1'b0, 8'hEF, 1'b1);
        add_row(8'h10,           1'b0, 8'h10, 1'b0);

        wait_cycles(3);
        rst = 1'b1;
        wait_cycles(2);
        check_display("after reset", GLYPH[0], GLYPH[0]);

        for (i = 0; i < n_rows; i++)
        begin
            send_frame(row_code[i], row_bad[i]);
            wait_cycles(SETTLE_CLKS);
            check_display($sformatf("row %0d, byte 0x%02h", i, row_code[i]),
                          row_hi[i], row_lo[i]);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- ps2_display.f
+incdir+include
verilog/ps2_display_pkg.sv
verilog/ps2_receiver.sv
verilog/key_tracker.sv
verilog/seg7_decoder.sv
verilog/ps2_display.sv
test/ps2_display_sva.sv
test/ps2_display_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ps2_display_tb \
    -f ps2_display.f -o ps2_display_sim

status=0
sim_out=$(./obj_dir/ps2_display_sim 2>&1) || status=$?
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qF "All tests passed!"; then
    exit 0
fi
echo "simulation failed, exit status $status" >&2
exit 1
